//--- sim.f
verilog/mem_bus_pkg.sv
verilog/arb_pkg.sv
verilog/mem_arbiter.sv
verilog/main_memory.sv
verilog/mem_subsystem.sv
tests/mem_arbiter_sva.sv
tests/mem_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_bin=mem_subsystem_tb

verilator --binary --timing --assert \
  --top-module mem_subsystem_tb \
  --Mdir "$build_dir" -o "$sim_bin" \
  -f sim.f
if [ $? -ne 0 ]; then
  echo "run_sim: verilator build failed"
  exit 1
fi

# keep going after an assertion error so the testbench still reports.
"./$build_dir/$sim_bin" +verilator+error+limit+1000 > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "run_sim: simulation exited with status $run_status"
  exit 1
fi

if grep -qx "sim passed" "$log_file"; then
  echo "run_sim: PASS"
  exit 0
fi
echo "run_sim: FAIL"
exit 1

//--- tests/mem_subsystem_tb.sv
`timescale 1ns/10ps

module mem_subsystem_tb;

  import mem_bus_pkg::*;
  import arb_pkg::*;

  localparam int NUM_ACCESSES = 400;  // completed accesses per run.

  logic     clk;
  logic     rst_n;
  logic     req_1;
  mem_req_t cmd_1;
  logic     grant_1;
  mem_rsp_t rsp_1;
  logic     req_2;
  mem_req_t cmd_2;
  logic     grant_2;
  mem_rsp_t rsp_2;

  integer            seed = 32'h9f17;          // fixed stimulus seed.
  int                errors;
  int                checks;
  int                done_count;               // accesses finished.
  int                cycle;                    // falling edges since reset.
  arb_state_e        exp_owner;                // model owner.
  int                age;                      // edges since model grant.
  int                gap [2];                  // idle cycles left per port.
  int                start_cycle [2];          // cycle the access was presented.
  bit                timed [2];                // presented to an idle arbiter.
  bit                both_wait;                // both waiting, none granted.
  bit                prev_hold_1;
  bit                prev_hold_2;
  logic [DATA_W-1:0] model_mem [2**ADDR_W];    // reference word array.
  bit                written [2**ADDR_W];      // word has a known value.

  mem_subsystem mem_subsystem_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_1   (req_1),
    .cmd_1   (cmd_1),
    .grant_1 (grant_1),
    .rsp_1   (rsp_1),
    .req_2   (req_2),
    .cmd_2   (cmd_2),
    .grant_2 (grant_2),
    .rsp_2   (rsp_2)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  // watchdog, sized from the access count and the latency.
  initial begin
    repeat (NUM_ACCESSES * (mem_subsystem_inst.MEM_LATENCY + 4) * 2) @(posedge clk);
    $display("timeout: only %0d of %0d accesses completed", done_count, NUM_ACCESSES);
    $display("sim failed");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
    errors++;
    $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR %s at %0t", what, $time);
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    checks++;
    assert (got === exp) else report_mismatch(name, got, exp);  // x counts as wrong.
  endtask

  // one rising edge of the owner model.
  task automatic advance_model();
    if (exp_owner == ARB_IDLE) begin
      if (req_1) begin
        exp_owner = ARB_PORT1;  // fetch wins from idle.
        age = 0;
      end else if (req_2) begin
        exp_owner = ARB_PORT2;
        age = 0;
      end
    end else if (age == mem_subsystem_inst.MEM_LATENCY) begin
      exp_owner = ARB_IDLE;     // done seen, released.
    end else begin
      age++;
    end
  endtask

  task automatic check_outputs();
    logic done_due;
    done_due = (age == mem_subsystem_inst.MEM_LATENCY);  // memory answers now.
    check_value("grant_1", DATA_W'(grant_1), DATA_W'(exp_owner == ARB_PORT1));
    check_value("grant_2", DATA_W'(grant_2), DATA_W'(exp_owner == ARB_PORT2));
    check_value("rsp_1.done", DATA_W'(rsp_1.done),
                DATA_W'(exp_owner == ARB_PORT1 && done_due));
    check_value("rsp_2.done", DATA_W'(rsp_2.done),
                DATA_W'(exp_owner == ARB_PORT2 && done_due));
    checks++;
    assert (!(grant_1 && grant_2)) else report_error("both grants high");
    checks++;
    assert ((!grant_1 || req_1) && (!grant_2 || req_2))
      else report_error("grant given to a port that is not requesting");
    if (both_wait) begin
      checks++;
      assert (grant_1) else report_error("port 1 did not win with both ports waiting");
    end
    if (prev_hold_1 || prev_hold_2) begin
      checks++;
      assert ((!prev_hold_1 || grant_1) && (!prev_hold_2 || grant_2))
        else report_error("grant taken away before done");
    end
  endtask

  task automatic serve_done(input port_e p, input mem_req_t cmd, input mem_rsp_t rsp);
    int    idx;
    string data_name;
    string lat_name;
    idx = int'(cmd.addr) % mem_subsystem_inst.MEM_WORDS;  // memory wraps.
    if (p == PORT1) begin
      data_name = "rsp_1.rdata";
      lat_name  = "rsp_1.done latency";
    end else begin
      data_name = "rsp_2.rdata";
      lat_name  = "rsp_2.done latency";
    end
    if (cmd.store) begin
      model_mem[idx] = cmd.wdata;  // write lands at done.
      written[idx]   = 1'b1;
    end else if (written[idx]) begin
      check_value(data_name, rsp.rdata, model_mem[idx]);
    end
    if (timed[p]) begin
      check_value(lat_name, DATA_W'(cycle - start_cycle[p]),
                  DATA_W'(1 + mem_subsystem_inst.MEM_LATENCY));
    end
    done_count++;
  endtask

  task automatic present_access(input port_e p);
    mem_req_t    cmd;
    logic [31:0] r;
    r         = $random(seed);
    cmd.store = r[0];
    cmd.addr  = ADDR_W'(r[4:1]);  // 16 words, many hits.
    cmd.wdata = $random(seed);
    start_cycle[p] = cycle;
    timed[p] = !grant_1 && !grant_2 && (p == PORT1 || !req_1);  // uncontended.
    if (p == PORT1) begin
      cmd_1 = cmd;
      req_1 = 1'b1;
    end else begin
      cmd_2 = cmd;
      req_2 = 1'b1;
    end
  endtask

  // requester rule, hold until done, then gap or next access.
  task automatic drive_agent(input port_e p, input logic got_done, input logic req_now);
    logic [31:0] r;
    if (got_done) begin
      r      = $random(seed);
      gap[p] = int'(r[1:0]);  // zero keeps req up.
      if (gap[p] == 0) begin
        present_access(p);
      end else if (p == PORT1) begin
        req_1 = 1'b0;
      end else begin
        req_2 = 1'b0;
      end
    end else if (!req_now) begin
      if (gap[p] > 0) begin
        gap[p]--;
      end
      if (gap[p] == 0) begin
        present_access(p);
      end
    end
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    done_count  = 0;
    cycle       = 0;
    exp_owner   = ARB_IDLE;
    age         = 0;
    both_wait   = 1'b0;
    prev_hold_1 = 1'b0;
    prev_hold_2 = 1'b0;
    gap[PORT1]  = 1;  // both start together, contention first.
    gap[PORT2]  = 1;
    timed[PORT1] = 1'b0;
    timed[PORT2] = 1'b0;
    rst_n = 1'b0;
    req_1 = 1'b0;
    cmd_1 = '0;
    req_2 = 1'b0;
    cmd_2 = '0;
    repeat (3) begin
      @(negedge clk);
      check_value("grant_1", DATA_W'(grant_1), '0);  // quiet in reset.
      check_value("grant_2", DATA_W'(grant_2), '0);
      check_value("rsp_1.done", DATA_W'(rsp_1.done), '0);
      check_value("rsp_2.done", DATA_W'(rsp_2.done), '0);
    end
    rst_n = 1'b1;
    while (done_count < NUM_ACCESSES) begin
      @(negedge clk);
      cycle++;
      advance_model();
      check_outputs();
      if (rsp_1.done) begin
        serve_done(PORT1, cmd_1, rsp_1);
      end
      if (rsp_2.done) begin
        serve_done(PORT2, cmd_2, rsp_2);
      end
      prev_hold_1 = grant_1 && !rsp_1.done;  // must stay granted.
      prev_hold_2 = grant_2 && !rsp_2.done;
      drive_agent(PORT1, rsp_1.done, req_1);  // port 1 first, sets timed for 2.
      drive_agent(PORT2, rsp_2.done, req_2);
      both_wait = !grant_1 && !grant_2 && req_1 && req_2;
    end
    $display("checks %0d, errors %0d, accesses %0d", checks, errors, done_count);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- tests/mem_arbiter_sva.sv
`timescale 1ns/10ps

module mem_arbiter_sva (
  input logic                  clk,      // arbiter clock.
  input logic                  rst_n,    // async reset, active low.
  input logic                  req_1,    // fetch request.
  input logic                  req_2,    // load/store request.
  input logic                  grant_1,  // fetch grant.
  input logic                  grant_2,  // load/store grant.
  input mem_bus_pkg::mem_rsp_t rsp_1,    // fetch answer.
  input mem_bus_pkg::mem_rsp_t rsp_2     // load/store answer.
);

  // one owner at a time.
  grants_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(grant_1 && grant_2))
    else $error("both grants are high");

  // requester may drop req once it has seen done.
  grant_1_requested: assert property (@(posedge clk) disable iff (!rst_n)
    grant_1 |-> (req_1 || rsp_1.done))
    else $error("port 1 granted without a request");

  grant_2_requested: assert property (@(posedge clk) disable iff (!rst_n)
    grant_2 |-> (req_2 || rsp_2.done))
    else $error("port 2 granted without a request");

  // no pre-emption before done.
  grant_1_held: assert property (@(posedge clk) disable iff (!rst_n)
    (grant_1 && !rsp_1.done) |=> grant_1)
    else $error("port 1 grant dropped before done");

  grant_2_held: assert property (@(posedge clk) disable iff (!rst_n)
    (grant_2 && !rsp_2.done) |=> grant_2)
    else $error("port 2 grant dropped before done");

endmodule

bind mem_arbiter mem_arbiter_sva mem_arbiter_sva_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_1   (req_1),
  .req_2   (req_2),
  .grant_1 (grant_1),
  .grant_2 (grant_2),
  .rsp_1   (rsp_1),
  .rsp_2   (rsp_2)
);

//--- verilog/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem #(
  parameter int MEM_WORDS   = 1024,  // memory depth in words.
  parameter int MEM_LATENCY = 3      // memory access edges.
) (
  input  logic                  clk,      // system clock.
  input  logic                  rst_n,    // async reset, active low.
  input  logic                  req_1,    // fetch request.
  input  mem_bus_pkg::mem_req_t cmd_1,    // fetch command.
  output logic                  grant_1,  // fetch grant.
  output mem_bus_pkg::mem_rsp_t rsp_1,    // fetch response.
  input  logic                  req_2,    // load/store request.
  input  mem_bus_pkg::mem_req_t cmd_2,    // load/store command.
  output logic                  grant_2,  // load/store grant.
  output mem_bus_pkg::mem_rsp_t rsp_2     // load/store response.
);

  import mem_bus_pkg::*;

  logic     mem_req;  // arbiter to memory request.
  mem_req_t mem_cmd;  // granted command.
  mem_rsp_t mem_rsp;  // memory answer.

  mem_arbiter mem_arbiter_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_1   (req_1),
    .cmd_1   (cmd_1),
    .req_2   (req_2),
    .cmd_2   (cmd_2),
    .grant_1 (grant_1),
    .grant_2 (grant_2),
    .rsp_1   (rsp_1),
    .rsp_2   (rsp_2),
    .mem_req (mem_req),
    .mem_cmd (mem_cmd),
    .mem_rsp (mem_rsp)
  );

  main_memory #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) main_memory_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .mem_cmd (mem_cmd),
    .mem_rsp (mem_rsp)
  );

endmodule

//--- verilog/main_memory.sv
`timescale 1ns/10ps

module main_memory #(
  parameter int MEM_WORDS   = 1024,  // word count, up to 2**ADDR_W.
  parameter int MEM_LATENCY = 3      // start to done in edges, >= 1.
) (
  input  logic                  clk,      // system clock.
  input  logic                  rst_n,    // async reset, active low.
  input  logic                  mem_req,  // access request level.
  input  mem_bus_pkg::mem_req_t mem_cmd,  // command, stable until done.
  output mem_bus_pkg::mem_rsp_t mem_rsp   // done pulse and read word.
);

  import mem_bus_pkg::*;

  // counter holds at most MEM_LATENCY-1.
  localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  logic [DATA_W-1:0] mem_array [MEM_WORDS];  // word storage.

  logic              busy_q;    // access in flight.
  logic [CNT_W-1:0]  cnt_q;     // edges left before done.
  logic              done_q;    // registered done pulse.
  logic [DATA_W-1:0] rdata_q;   // registered read word.
  logic              start;     // access begins this edge.
  logic              finish;    // access completes this edge.
  logic [ADDR_W-1:0] word_idx;  // address folded into the array.

  // no new start while done is still out.
  // the arbiter drops mem_req on the edge that samples done.
  assign start = mem_req & ~busy_q & ~done_q;

  // single edge access when latency is one.
  assign finish = (busy_q & (cnt_q == CNT_W'(1))) | (start & (MEM_LATENCY == 1));

  assign word_idx = ADDR_W'(mem_cmd.addr % MEM_WORDS);  // wrap out of range.

  // access timing.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;        // idle out of reset.
      cnt_q  <= '0;
      done_q <= 1'b0;        // no stray done.
    end else begin
      done_q <= finish;      // one cycle pulse.
      if (finish) begin
        busy_q <= 1'b0;      // back to idle.
      end else if (start) begin
        busy_q <= 1'b1;      // begin multi edge access.
        cnt_q  <= CNT_W'(MEM_LATENCY - 1);
      end else if (busy_q) begin
        cnt_q  <= cnt_q - CNT_W'(1);  // count down.
      end
    end
  end

  // storage and read port.
  // both act on the edge that raises done.
  always_ff @(posedge clk) begin
    if (finish) begin
      if (mem_cmd.store) begin
        mem_array[word_idx] <= mem_cmd.wdata;  // commit write.
      end
      rdata_q <= mem_array[word_idx];          // stored word.
    end
  end

  assign mem_rsp.done  = done_q;
  assign mem_rsp.rdata = rdata_q;

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
  input  logic                 clk,      // system clock.
  input  logic                 rst_n,    // async reset, active low.
  input  logic                 req_1,    // fetch request level.
  input  mem_bus_pkg::mem_req_t cmd_1,   // fetch command.
  input  logic                 req_2,    // load/store request level.
  input  mem_bus_pkg::mem_req_t cmd_2,   // load/store command.
  output logic                 grant_1,  // fetch owns the bus.
  output logic                 grant_2,  // load/store owns the bus.
  output mem_bus_pkg::mem_rsp_t rsp_1,   // answer to fetch.
  output mem_bus_pkg::mem_rsp_t rsp_2,   // answer to load/store.
  output logic                 mem_req,  // access request to memory.
  output mem_bus_pkg::mem_req_t mem_cmd, // granted command.
  input  mem_bus_pkg::mem_rsp_t mem_rsp  // memory answer.
);

  import arb_pkg::*;

  arb_state_e owner_q;  // current owner.
  arb_state_e owner_d;  // owner after this edge.
  port_e      sel;      // port steering the mux.

  // next owner.
  // port 1 wins from idle; an owner is only released by done,
  // so a running port 2 access is never pre-empted.
  always_comb begin
    owner_d = owner_q;  // hold by default.
    case (owner_q)
      ARB_IDLE: begin
        if (req_1) begin
          owner_d = ARB_PORT1;  // fetch has priority.
        end else if (req_2) begin
          owner_d = ARB_PORT2;  // load/store when fetch is quiet.
        end
      end
      ARB_PORT1, ARB_PORT2: begin
        if (mem_rsp.done) begin
          owner_d = ARB_IDLE;  // release, rearbitrate next edge.
        end
      end
      default: begin
        owner_d = ARB_IDLE;  // recover from illegal code.
      end
    endcase
  end

  // owner register, rising edge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= ARB_IDLE;  // no grant out of reset.
    end else begin
      owner_q <= owner_d;
    end
  end

  // grant decode, straight from the register.
  assign grant_1 = (owner_q == ARB_PORT1);  // fetch granted.
  assign grant_2 = (owner_q == ARB_PORT2);  // load/store granted.
  assign mem_req = grant_1 | grant_2;       // any grant drives memory.

  // port 1 is the default mux leg when idle.
  assign sel = grant_2 ? PORT2 : PORT1;

  // command mux toward memory.
  assign mem_cmd = (sel == PORT2) ? cmd_2 : cmd_1;

  // response routing.
  // done only reaches the owner, rdata fans out to both.
  assign rsp_1.done  = mem_rsp.done & mem_req & (sel == PORT1);  // fetch done.
  assign rsp_1.rdata = mem_rsp.rdata;                            // shared read bus.
  assign rsp_2.done  = mem_rsp.done & mem_req & (sel == PORT2);  // load/store done.
  assign rsp_2.rdata = mem_rsp.rdata;                            // shared read bus.

endmodule

//--- verilog/arb_pkg.sv
package arb_pkg;

  // who currently owns the memory bus.
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,  // nobody granted.
    ARB_PORT1 = 2'd1,  // instruction fetch granted.
    ARB_PORT2 = 2'd2   // load/store granted.
  } arb_state_e;

  // names one requester.
  typedef enum logic {
    PORT1 = 1'b0,  // instruction fetch.
    PORT2 = 1'b1   // load/store.
  } port_e;

endpackage

//--- verilog/mem_bus_pkg.sv
package mem_bus_pkg;

  // memory bus geometry.
  localparam int ADDR_W = 10;  // word address bits.
  localparam int DATA_W = 32;  // data word bits.

  // one access as a requester presents it.
  // the same layout is used on the arbiter to memory side.
  typedef struct packed {
    logic              store;  // 1 = write, 0 = read.
    logic [ADDR_W-1:0] addr;   // word address.
    logic [DATA_W-1:0] wdata;  // write data, ignored on reads.
  } mem_req_t;

  // memory answer, routed back to the owning port.
  typedef struct packed {
    logic              done;   // single cycle completion pulse.
    logic [DATA_W-1:0] rdata;  // read word, valid with done.
  } mem_rsp_t;

endpackage
